// ==== design/spi_flash_pkg.sv ====
package spi_flash_pkg;

	//--------------------------------------------------------------------------
	// flash command set
	typedef enum logic [7:0] {
		OP_RESET = 8'hF0,	// software reset
		OP_READ  = 8'h03,	// normal read
		OP_WREN  = 8'h06,	// write enable
		OP_SE    = 8'hD8,	// sector erase
		OP_PP    = 8'h02,	// page program
		OP_RDSR  = 8'h05	// read status register 1
	} flash_op_t;

	localparam int ADDR_BYTES = 3;	// 24 bit address
	localparam int DATA_BYTES = 4;	// bytes per host word
	localparam int WIP_BIT    = 0;	// write in progress, status reg 1

	typedef logic [23:0] addr_t;
	typedef logic [31:0] word_t;	// byte 0 goes out first

	//--------------------------------------------------------------------------
	// APB register map
	typedef enum logic [7:0] {
		REG_CTRL   = 8'h00,
		REG_ADDR   = 8'h04,
		REG_WDATA  = 8'h08,
		REG_RDATA  = 8'h0C,
		REG_STATUS = 8'h10
	} reg_off_t;

	localparam int CTRL_GO   = 0;	// start operation
	localparam int CTRL_RNW  = 1;	// 1 read, 0 write
	localparam int ST_BUSY   = 0;
	localparam int ST_DONE   = 1;	// sticky until next go
	localparam int ST_READY  = 2;	// reset cmd and settle time passed

endpackage

// ==== design/flash_cmd_if.sv ====
`timescale 1ns/1ps

// one host command, register block to sequencer
interface flash_cmd_if;
	logic                 go;	// single cycle pulse
	logic                 is_read;
	spi_flash_pkg::addr_t addr;
	spi_flash_pkg::word_t wdata;
	spi_flash_pkg::word_t rdata;	// valid when busy falls
	logic                 busy;
	logic                 ready;

	modport regs (
		output go, is_read, addr, wdata,
		input  rdata, busy, ready
	);

	modport seq (
		input  go, is_read, addr, wdata,
		output rdata, busy, ready
	);
endinterface

// ==== design/spi_byte_if.sv ====
`timescale 1ns/1ps

// one byte on the wire, sequencer to shifter
interface spi_byte_if;
	logic       start;	// pulse, only while idle
	logic [7:0] tx_byte;
	logic       hold_cs;	// keep cs low after this byte
	logic       done;	// pulse per byte
	logic [7:0] rx_byte;	// valid with done

	modport seq (
		output start, tx_byte, hold_cs,
		input  done, rx_byte
	);

	modport shifter (
		input  start, tx_byte, hold_cs,
		output done, rx_byte
	);
endinterface

// ==== design/apb_flash_regs.sv ====
`timescale 1ns/1ps

module apb_flash_regs (
	input  logic        clk,
	input  logic        rst,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [7:0]  paddr_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic        pslverr_o,
	flash_cmd_if.regs   cmd
);
	logic                 access;	// apb access phase
	logic                 mapped;
	logic                 ctrl_wr;
	logic                 go_bad;	// go while busy or not ready
	logic                 go_q;
	logic                 rnw_q;
	logic                 done_q;
	logic                 busy_d;	// for falling edge of busy
	logic [31:0]          rd_word;
	spi_flash_pkg::addr_t addr_q;
	spi_flash_pkg::word_t wdata_q;

	assign access  = psel_i & penable_i;
	assign ctrl_wr = access & pwrite_i & (paddr_i == spi_flash_pkg::REG_CTRL);
	assign go_bad  = ctrl_wr & pwdata_i[spi_flash_pkg::CTRL_GO]
		& (cmd.busy | ~cmd.ready | go_q);

	always_comb begin
		mapped  = 1'b1;
		rd_word = '0;
		case (paddr_i)
			spi_flash_pkg::REG_CTRL:   rd_word[spi_flash_pkg::CTRL_RNW] = rnw_q;
			spi_flash_pkg::REG_ADDR:   rd_word = {8'd0, addr_q};
			spi_flash_pkg::REG_WDATA:  rd_word = wdata_q;
			spi_flash_pkg::REG_RDATA:  rd_word = cmd.rdata;
			spi_flash_pkg::REG_STATUS: begin
				rd_word[spi_flash_pkg::ST_BUSY]  = cmd.busy;
				rd_word[spi_flash_pkg::ST_DONE]  = done_q;
				rd_word[spi_flash_pkg::ST_READY] = cmd.ready;
			end
			default: mapped = 1'b0;	// hole in the map
		endcase
	end

	assign prdata_o  = (access & ~pwrite_i) ? rd_word : '0;
	assign pslverr_o = access & (~mapped | go_bad);

	//--------------------------------------------------------------------------
	// control and sticky status
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			go_q   <= 1'b0;
			rnw_q  <= 1'b0;
			done_q <= 1'b0;
			busy_d <= 1'b0;
		end else begin
			busy_d <= cmd.busy;
			go_q   <= ctrl_wr & pwdata_i[spi_flash_pkg::CTRL_GO] & ~go_bad;	// one cycle
			if (ctrl_wr & ~go_bad)
				rnw_q <= pwdata_i[spi_flash_pkg::CTRL_RNW];
			if (ctrl_wr & pwdata_i[spi_flash_pkg::CTRL_GO] & ~go_bad)
				done_q <= 1'b0;	// new op clears done
			else if (busy_d & ~cmd.busy)
				done_q <= 1'b1;	// op just finished
		end
	end

	always_ff @(posedge clk) begin
		if (access & pwrite_i & (paddr_i == spi_flash_pkg::REG_ADDR))
			addr_q <= pwdata_i[23:0];
		if (access & pwrite_i & (paddr_i == spi_flash_pkg::REG_WDATA))
			wdata_q <= pwdata_i;
	end

	assign cmd.go      = go_q;
	assign cmd.is_read = rnw_q;
	assign cmd.addr    = addr_q;
	assign cmd.wdata   = wdata_q;
endmodule

// ==== design/flash_sequencer.sv ====
`timescale 1ns/1ps

module flash_sequencer #(
	parameter int RESET_WAIT = 20000
) (
	input  logic     clk,
	input  logic     rst,
	flash_cmd_if.seq cmd,
	spi_byte_if.seq  xfer
);
	localparam int WAIT_W = $clog2(RESET_WAIT + 1);

	//--------------------------------------------------------------------------
	// states
	localparam logic [3:0] S_RST_CMD   = 4'd0,	// send 0xF0
	                       S_SETTLE    = 4'd1,	// wait after reset cmd
	                       S_IDLE      = 4'd2,
	                       S_OPCODE    = 4'd3,	// read, erase or program opcode
	                       S_ADDR      = 4'd4,	// 3 address bytes
	                       S_RDATA     = 4'd5,	// read data bytes in
	                       S_WDATA     = 4'd6,	// program data bytes out
	                       S_WREN      = 4'd7,	// write enable
	                       S_POLL_OP   = 4'd8,	// read status opcode
	                       S_POLL_DATA = 4'd9,	// status bytes until wip clear
	                       S_POLL_END  = 4'd10;	// last dummy, releases cs

	logic [3:0]               state;
	logic                     pend;	// byte in flight
	logic                     busy_q;
	logic                     ready_q;
	logic                     phase;	// 0 erase, 1 program
	logic [1:0]               addr_cnt;
	logic [1:0]               data_cnt;
	logic [WAIT_W-1:0]        wait_cnt;
	logic                     last_addr;
	logic                     last_data;
	logic                     xfer_st;	// state moves bytes
	logic [7:0]               tx_byte;
	logic                     hold;
	spi_flash_pkg::flash_op_t op_q;
	spi_flash_pkg::addr_t     addr_q;
	spi_flash_pkg::word_t     wdata_q;
	spi_flash_pkg::word_t     rdata_q;

	assign last_addr = addr_cnt == 2'(spi_flash_pkg::ADDR_BYTES - 1);
	assign last_data = data_cnt == 2'(spi_flash_pkg::DATA_BYTES - 1);

	// byte to send in the current state
	always_comb begin
		xfer_st = 1'b1;
		tx_byte = 8'h00;	// dummy for reads
		hold    = 1'b1;
		case (state)
			S_RST_CMD: begin
				tx_byte = spi_flash_pkg::OP_RESET;
				hold    = 1'b0;
			end
			S_OPCODE:  tx_byte = op_q;
			S_ADDR: begin
				tx_byte = 8'(addr_q >> (8 * (spi_flash_pkg::ADDR_BYTES - 1 - int'(addr_cnt))));
				hold    = ~(last_addr & (op_q == spi_flash_pkg::OP_SE));	// erase ends here
			end
			S_RDATA:   hold = ~last_data;
			S_WDATA: begin
				tx_byte = 8'(wdata_q >> (8 * int'(data_cnt)));	// byte 0 first
				hold    = ~last_data;
			end
			S_WREN: begin
				tx_byte = spi_flash_pkg::OP_WREN;
				hold    = 1'b0;
			end
			S_POLL_OP:   tx_byte = spi_flash_pkg::OP_RDSR;
			S_POLL_DATA: hold = 1'b1;	// keep reading status
			S_POLL_END:  hold = 1'b0;
			default:     xfer_st = 1'b0;	// settle, idle
		endcase
	end

	assign xfer.start   = xfer_st & ~pend;
	assign xfer.tx_byte = tx_byte;
	assign xfer.hold_cs = hold;

	//--------------------------------------------------------------------------
	// main FSM
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= S_RST_CMD;
			pend     <= 1'b0;
			busy_q   <= 1'b0;
			ready_q  <= 1'b0;
			phase    <= 1'b0;
			addr_cnt <= '0;
			data_cnt <= '0;
			wait_cnt <= '0;
			op_q     <= spi_flash_pkg::OP_RESET;
		end else begin
			if (xfer.start)
				pend <= 1'b1;
			else if (xfer.done)
				pend <= 1'b0;
			case (state)
				S_RST_CMD: if (xfer.done) state <= S_SETTLE;
				S_SETTLE: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == WAIT_W'(RESET_WAIT - 1)) begin
						ready_q <= 1'b1;
						state   <= S_IDLE;
					end
				end
				S_IDLE: if (cmd.go) begin
					busy_q   <= 1'b1;
					phase    <= 1'b0;
					addr_cnt <= '0;
					data_cnt <= '0;
					op_q     <= spi_flash_pkg::OP_READ;
					state    <= cmd.is_read ? S_OPCODE : S_WREN;	// writes start with wren
				end
				S_OPCODE: if (xfer.done) state <= S_ADDR;
				S_ADDR: if (xfer.done) begin
					addr_cnt <= addr_cnt + 1'b1;
					if (last_addr) begin
						addr_cnt <= '0;
						case (op_q)
							spi_flash_pkg::OP_READ: state <= S_RDATA;
							spi_flash_pkg::OP_PP:   state <= S_WDATA;
							default:                state <= S_POLL_OP;	// erase
						endcase
					end
				end
				S_RDATA: if (xfer.done) begin
					data_cnt <= data_cnt + 1'b1;
					if (last_data) begin
						busy_q <= 1'b0;	// rdata complete this edge
						state  <= S_IDLE;
					end
				end
				S_WDATA: if (xfer.done) begin
					data_cnt <= data_cnt + 1'b1;
					if (last_data)
						state <= S_POLL_OP;
				end
				S_WREN: if (xfer.done) begin
					op_q  <= phase ? spi_flash_pkg::OP_PP : spi_flash_pkg::OP_SE;
					state <= S_OPCODE;
				end
				S_POLL_OP: if (xfer.done) state <= S_POLL_DATA;
				S_POLL_DATA:
					if (xfer.done & ~xfer.rx_byte[spi_flash_pkg::WIP_BIT])
						state <= S_POLL_END;
				S_POLL_END: if (xfer.done) begin
					if (phase) begin
						busy_q <= 1'b0;	// program finished
						state  <= S_IDLE;
					end else begin
						phase <= 1'b1;	// erase done, program next
						state <= S_WREN;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// payload, latched on go
	always_ff @(posedge clk) begin
		if (state == S_IDLE && cmd.go) begin
			addr_q  <= cmd.addr;
			wdata_q <= cmd.wdata;
		end
		if (state == S_RDATA && xfer.done)
			rdata_q <= {xfer.rx_byte, rdata_q[31:8]};	// little endian fill
	end

	assign cmd.rdata = rdata_q;
	assign cmd.busy  = busy_q;
	assign cmd.ready = ready_q;
endmodule

// ==== design/spi_byte_shifter.sv ====
`timescale 1ns/1ps

module spi_byte_shifter #(
	parameter int CLK_DIV = 4
) (
	input  logic        clk,
	input  logic        rst,
	spi_byte_if.shifter xfer,
	output logic        sclk_o,
	output logic        cs_n_o,
	output logic        mosi_o,
	input  logic        miso_i
);
	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;	// clk cycles per half period
	logic [2:0]       bit_cnt;	// falling edges seen
	logic             run;
	logic             tick;	// sclk edge this cycle
	logic             sclk_q;
	logic             cs_n_q;
	logic             hold_q;
	logic             done_q;
	logic [7:0]       tx_sh;
	logic [7:0]       rx_sh;

	assign tick = run & (div_cnt == DIV_W'(CLK_DIV - 1));

	//--------------------------------------------------------------------------
	// divider, edge counter, chip select
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			div_cnt <= '0;
			bit_cnt <= '0;
			run     <= 1'b0;
			sclk_q  <= 1'b0;	// mode 0 idles low
			cs_n_q  <= 1'b1;
			hold_q  <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (xfer.start) begin
				run     <= 1'b1;
				cs_n_q  <= 1'b0;
				hold_q  <= xfer.hold_cs;
				div_cnt <= '0;
				bit_cnt <= '0;
			end else if (run) begin
				div_cnt <= tick ? '0 : div_cnt + 1'b1;
				if (tick) begin
					sclk_q <= ~sclk_q;
					if (sclk_q) begin	// falling edge
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							run    <= 1'b0;
							done_q <= 1'b1;
							cs_n_q <= ~hold_q;	// release unless held
						end
					end
				end
			end
		end
	end

	// shift registers, msb first
	always_ff @(posedge clk) begin
		if (xfer.start)
			tx_sh <= xfer.tx_byte;
		else if (tick & sclk_q)
			tx_sh <= {tx_sh[6:0], 1'b0};	// next bit on falling edge
		if (tick & ~sclk_q)
			rx_sh <= {rx_sh[6:0], miso_i};	// sample on rising edge
	end

	assign sclk_o       = sclk_q;
	assign cs_n_o       = cs_n_q;
	assign mosi_o       = tx_sh[7];
	assign xfer.done    = done_q;
	assign xfer.rx_byte = rx_sh;
endmodule

// ==== design/spi_flash_ctrl.sv ====
`timescale 1ns/1ps

module spi_flash_ctrl #(
	parameter int CLK_DIV    = 4,	// clk cycles per sclk half period
	parameter int RESET_WAIT = 20000	// settle cycles after reset cmd
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [7:0]  paddr_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic        pslverr_o,
	output logic        sclk_o,
	output logic        cs_n_o,
	output logic        mosi_o,
	input  logic        miso_i
);
	flash_cmd_if cmd_if ();	// regs to sequencer
	spi_byte_if  byte_if ();	// sequencer to shifter

	apb_flash_regs regs_inst (
		.clk       (clk),
		.rst       (rst),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.prdata_o  (prdata_o),
		.pslverr_o (pslverr_o),
		.cmd       (cmd_if.regs)
	);

	flash_sequencer #(.RESET_WAIT(RESET_WAIT)) seq_inst (
		.clk  (clk),
		.rst  (rst),
		.cmd  (cmd_if.seq),
		.xfer (byte_if.seq)
	);

	spi_byte_shifter #(.CLK_DIV(CLK_DIV)) shifter_inst (
		.clk    (clk),
		.rst    (rst),
		.xfer   (byte_if.shifter),
		.sclk_o (sclk_o),
		.cs_n_o (cs_n_o),
		.mosi_o (mosi_o),
		.miso_i (miso_i)
	);
endmodule

// ==== tb/flash_model.sv ====
`timescale 1ns/1ps

module flash_model (
	input  logic sclk_i,
	input  logic cs_n_i,
	input  logic mosi_i,
	output logic miso_o
);
	localparam int MEM_SIZE = 1024;	// indexed by low address bits

	logic [7:0]  mem [MEM_SIZE];
	logic [7:0]  data_buf [4];	// program bytes of this command
	logic [7:0]  in_sh;
	logic [7:0]  out_sh;
	logic [7:0]  resp;	// byte to send next
	logic [7:0]  cmd;	// opcode of this cs low period
	logic [23:0] addr;
	logic        wel;	// write enable latch
	logic        early_cmd;	// command before any reset
	int          bit_cnt;
	int          byte_cnt;
	int          busy_cnt;	// status bytes left with wip set
	int          reset_cnt;

	initial begin
		for (int i = 0; i < MEM_SIZE; i++)
			mem[10'(i)] = 8'(i ^ (i >> 2));	// all 10 address bits matter
		in_sh     = 8'h00;
		out_sh    = 8'h00;
		resp      = 8'h00;
		addr      = '0;
		wel       = 1'b0;
		early_cmd = 1'b0;
		bit_cnt   = 0;
		byte_cnt  = 0;
		busy_cnt  = 0;
		reset_cnt = 0;
	end

	assign miso_o = out_sh[7];

	always @(negedge cs_n_i) begin	// new command
		bit_cnt  = 0;
		byte_cnt = 0;
		cmd      = 8'h00;
		resp     = 8'h00;
		out_sh   = 8'h00;
	end

	//--------------------------------------------------------------------------
	// receive on rising sclk, decode per byte
	always @(posedge sclk_i) begin
		if (!cs_n_i) begin
			in_sh = {in_sh[6:0], mosi_i};
			bit_cnt++;
			if (bit_cnt == 8) begin
				bit_cnt = 0;
				if (byte_cnt == 0) begin
					cmd = in_sh;
					if (in_sh == spi_flash_pkg::OP_RESET)
						reset_cnt++;
					else if (reset_cnt == 0)
						early_cmd = 1'b1;	// flash not yet reset
				end else if (byte_cnt <= spi_flash_pkg::ADDR_BYTES)
					addr = {addr[15:0], in_sh};	// msb first
				else if (byte_cnt <= spi_flash_pkg::ADDR_BYTES + spi_flash_pkg::DATA_BYTES)
					data_buf[2'(byte_cnt - spi_flash_pkg::ADDR_BYTES - 1)] = in_sh;
				if (cmd == spi_flash_pkg::OP_RDSR) begin
					resp = {7'd0, busy_cnt != 0};	// wip in bit 0
					if (busy_cnt != 0)
						busy_cnt--;
				end else if (cmd == spi_flash_pkg::OP_READ &&
					byte_cnt >= spi_flash_pkg::ADDR_BYTES)
					resp = mem[10'(addr + 24'(byte_cnt - spi_flash_pkg::ADDR_BYTES))];
				byte_cnt++;
			end
		end
	end

	always @(negedge sclk_i) begin	// mode 0, miso moves on falling sclk
		if (!cs_n_i)
			out_sh = (bit_cnt == 0) ? resp : {out_sh[6:0], 1'b0};
	end

	// commands take effect when cs rises
	always @(posedge cs_n_i) begin
		case (cmd)
			spi_flash_pkg::OP_WREN: wel = 1'b1;
			spi_flash_pkg::OP_SE: if (wel && byte_cnt > spi_flash_pkg::ADDR_BYTES) begin
				for (int i = 0; i < MEM_SIZE; i++)
					mem[10'(i)] = 8'hFF;	// whole array
				wel      = 1'b0;
				busy_cnt = 3;
			end
			spi_flash_pkg::OP_PP: if (wel) begin
				for (int i = 0; i < byte_cnt - 4 && i < 4; i++)
					mem[10'(addr + 24'(i))] &= data_buf[2'(i)];	// program only clears bits
				wel      = 1'b0;
				busy_cnt = 3;
			end
			default: ;
		endcase
	end
endmodule

// ==== tb/tb_spi_flash_ctrl.sv ====
`timescale 1ns/1ps

module tb_spi_flash_ctrl;
	localparam int POLL_MAX = 2000;	// status reads per wait

	logic        clk;
	logic        rst;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pslverr;
	logic        sclk;
	logic        cs_n;
	logic        mosi;
	logic        miso;
	integer      seed;
	int          errors;
	int          errors_at_start;
	int          tests;
	int          failed_tests;
	logic [23:0] addr_a;
	logic [23:0] addr_b;
	logic [31:0] word_a;
	logic [31:0] word_b;
	logic [31:0] rd;
	logic        err;

	spi_flash_ctrl #(.CLK_DIV(2), .RESET_WAIT(50)) spi_flash_ctrl_inst (
		.clk       (clk),
		.rst       (rst),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pslverr_o (pslverr),
		.sclk_o    (sclk),
		.cs_n_o    (cs_n),
		.mosi_o    (mosi),
		.miso_i    (miso)
	);

	flash_model model_inst (.sclk_i(sclk), .cs_n_i(cs_n), .mosi_i(mosi), .miso_o(miso));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 100 MHz
	end

	//--------------------------------------------------------------------------
	// checks and reporting
	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == errors_at_start)
			$display("test %0d %s: pass", tests, name);
		else begin
			failed_tests++;
			$display("test %0d %s: fail", tests, name);
		end
		errors_at_start = errors;
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timed out waiting for %s", what);
		$display("Test failed");
		$finish;
	endtask

	function automatic logic [31:0] model_word(input logic [23:0] a);
		logic [31:0] w;
		for (int i = 0; i < 4; i++)
			w[8*i +: 8] = model_inst.mem[10'(a + 24'(i))];	// little endian
		return w;
	endfunction

	//--------------------------------------------------------------------------
	// APB access on falling clk
	task automatic apb_write(input logic [7:0] a, input logic [31:0] d, output logic slv_err);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = a;
		pwdata  = d;
		@(negedge clk);
		penable = 1'b1;
		#1 slv_err = pslverr;	// between clk edges
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] a, output logic [31:0] d, output logic slv_err);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = a;
		@(negedge clk);
		penable = 1'b1;
		#1;
		d       = prdata;
		slv_err = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_status(input int bit_idx, input logic val, input string what);
		logic [31:0] st;
		logic        bad;
		int          n;
		n = 0;
		apb_read(spi_flash_pkg::REG_STATUS, st, bad);
		while (st[5'(bit_idx)] !== val && n < POLL_MAX) begin
			apb_read(spi_flash_pkg::REG_STATUS, st, bad);
			n++;
		end
		if (st[5'(bit_idx)] !== val)
			stop_on_timeout(what);
	endtask

	task automatic start_op(input logic rnw, input logic [23:0] a, input logic [31:0] d);
		logic [31:0] st;
		logic        bad;
		apb_write(spi_flash_pkg::REG_ADDR, {8'd0, a}, bad);
		check_val("pslverr_o on ADDR write", 32'(bad), 32'h0);
		apb_write(spi_flash_pkg::REG_WDATA, d, bad);
		check_val("pslverr_o on WDATA write", 32'(bad), 32'h0);
		apb_write(spi_flash_pkg::REG_CTRL, {30'd0, rnw, 1'b1}, bad);	// rnw and go
		check_val("pslverr_o on go", 32'(bad), 32'h0);
		apb_read(spi_flash_pkg::REG_STATUS, st, bad);
		check_val("STATUS busy after go", 32'(st[spi_flash_pkg::ST_BUSY]), 32'h1);
	endtask

	task automatic finish_op();
		logic [31:0] st;
		logic        bad;
		wait_status(spi_flash_pkg::ST_DONE, 1'b1, "done after an operation");
		apb_read(spi_flash_pkg::REG_STATUS, st, bad);
		check_val("STATUS busy with done", 32'(st[spi_flash_pkg::ST_BUSY]), 32'h0);
	endtask

	task automatic read_flash(input logic [23:0] a, output logic [31:0] w);
		logic bad;
		start_op(1'b1, a, 32'h0);
		finish_op();
		apb_read(spi_flash_pkg::REG_RDATA, w, bad);
	endtask

	//--------------------------------------------------------------------------
	// stimulus
	initial begin
		seed            = 32'he4555311;
		errors          = 0;
		errors_at_start = 0;
		tests           = 0;
		failed_tests    = 0;
		rst             = 1'b1;
		psel            = 1'b0;
		penable         = 1'b0;
		pwrite          = 1'b0;
		paddr           = 8'h00;
		pwdata          = 32'h0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		#1;	// before the first active edge
		check_val("cs_n_o after reset", 32'(cs_n), 32'h1);
		check_val("sclk_o after reset", 32'(sclk), 32'h0);
		apb_read(spi_flash_pkg::REG_STATUS, rd, err);
		check_val("STATUS after reset", rd, 32'h0);
		wait_status(spi_flash_pkg::ST_READY, 1'b1, "ready after the reset command");
		check_true(model_inst.reset_cnt == 1, "flash did not see exactly one reset command");
		check_true(!model_inst.early_cmd, "a command reached the flash before its reset");
		end_test("reset state");

		addr_a = 24'($random(seed));
		word_a = $random(seed);
		start_op(1'b0, addr_a, word_a);
		finish_op();
		check_val("flash memory at A", model_word(addr_a), word_a);
		end_test("write and completion");

		read_flash(addr_a, rd);
		check_val("prdata_o RDATA at A", rd, word_a);
		end_test("read-back");

		addr_b       = 24'($random(seed));
		addr_b[9:0]  = addr_a[9:0] ^ 10'h200;	// no byte shared with A
		word_b       = $random(seed);
		start_op(1'b0, addr_b, word_b);
		finish_op();
		read_flash(addr_b, rd);
		check_val("prdata_o RDATA at B", rd, word_b);
		read_flash(addr_a, rd);
		check_val("prdata_o RDATA at erased A", rd, 32'hFFFF_FFFF);
		end_test("erase effect");

		start_op(1'b1, addr_b, 32'h0);
		apb_write(spi_flash_pkg::REG_CTRL, 32'h1, err);	// write go into a running read
		check_val("pslverr_o on go while busy", 32'(err), 32'h1);
		finish_op();
		apb_read(spi_flash_pkg::REG_RDATA, rd, err);
		check_val("prdata_o RDATA after rejected go", rd, word_b);
		apb_read(spi_flash_pkg::REG_CTRL, rd, err);
		check_val("prdata_o CTRL rnw after rejected go",
			32'(rd[spi_flash_pkg::CTRL_RNW]), 32'h1);
		apb_read(8'h14, rd, err);
		check_val("pslverr_o on read of 0x14", 32'(err), 32'h1);
		apb_write(8'h14, 32'h0, err);
		check_val("pslverr_o on write of 0x14", 32'(err), 32'h1);
		end_test("bus errors");

		$display("tests %0d, failed tests %0d, failed checks %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end
endmodule

// ==== compile.f ====
design/spi_flash_pkg.sv
design/flash_cmd_if.sv
design/spi_byte_if.sv
design/apb_flash_regs.sv
design/flash_sequencer.sv
design/spi_byte_shifter.sv
design/spi_flash_ctrl.sv
tb/flash_model.sv
tb/tb_spi_flash_ctrl.sv

// ==== Makefile ====
TOP := tb_spi_flash_ctrl

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "Test completed successfully"

clean:
	rm -rf obj_dir
